//--- Bender.yml
package:
  name: g729_encoder_control

sources:
  - files:
      - rtl/g729Pkg.sv
      - rtl/frameGate.sv
      - rtl/encoderSchedule.sv
      - rtl/stepSequencer.sv
      - rtl/encoderControl.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/encoderControlTb.sv

//--- bench/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic clock,
	output logic reset
);
	localparam int resetCycles = 3;

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock; // 8 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- bench/encoderControlTb.sv
`timescale 1ns/1ps

module encoderControlTb;
	import g729Pkg::*;

	typedef struct packed {
		unitId_t    unit;
		stepIndex_t step;
		logic [5:0] offset;
	} expectRow_t;

	localparam int passCount  = frameLength / subframeLength;
	localparam int stepCount  = frameSteps + passCount * subframeSteps - (passCount - 1);
	localparam int slotCycles = 8;  // Worst step of 6 busy cycles plus a gap
	localparam int runCount   = 3;
	localparam int gatePause  = 5;  // Idle cycles before each frameDone
	localparam int idleWatch  = 40;
	localparam int abortRow   = 30; // Parity pitch in the first subframe
	localparam int timeoutCycles = runCount * stepCount * slotCycles
		+ runCount * framesPerAnalysis * (gatePause + 1) + gatePause + 1
		+ runCount * (idleWatch + 4) + 16;

	logic       clock;
	logic       reset;
	logic       start;
	logic       frameDone;
	logic       divErr;
	unitFlags_t unitDone;
	unitFlags_t unitStart;
	stepIndex_t mathSel;
	logic [5:0] subframe;
	logic       encodeDone;
	expectRow_t expectTable [stepCount];
	int         cycleCount = 0;

	clockGen clocks
	(
		.clock (clock),
		.reset (reset)
	);

	encoderControl dut
	(
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.frameDone  (frameDone),
		.divErr     (divErr),
		.unitDone   (unitDone),
		.unitStart  (unitStart),
		.mathSel    (mathSel),
		.subframe   (subframe),
		.encodeDone (encodeDone)
	);

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: the encoder did not finish within %0d cycles", timeoutCycles);
			$display("TESTBENCH FAILED");
			$fatal(1, "Run stopped by timeout");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, actual,
				expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic unitFlags_t startFlag(input unitId_t unit);
		unitFlags_t flags;
		flags = '0;
		flags[unit] = 1'b1; // autocorr at bit 0
		return flags;
	endfunction

	////////////////////////////////////////
	// Expected start order
	////////////////////////////////////////

	task automatic buildTable();
		unitId_t frameOrder [frameSteps];
		unitId_t subframeOrder [subframeSteps];
		int      row;
		int      pass;
		int      k;
		frameOrder = '{autocorr, lagWindow, levinson, azToLsp, quaLsp, intLpc, intQlpc,
			math1, percVar, weightAz, weightAz, residu, synFilt, weightAz, weightAz,
			residu, synFilt, pitchOl, math2};
		subframeOrder = '{weightAz, weightAz, math3, synFilt, synFilt, residu, synFilt,
			residu, synFilt, pitchFr3, encLag3, parityPitch, predLt3, convolve, gPitch,
			testErr, math4, acelpCodebook, math5, corrXy2, quaGain, math6, updateExcErr,
			synFilt, math7};
		row = 0;
		for (k = 0; k < frameSteps; k++)
		begin
			expectTable[row] = '{frameOrder[k], stepIndex_t'(k), 6'd0};
			row++;
		end
		for (pass = 0; pass < passCount; pass++)
		begin
			for (k = 0; k < subframeSteps; k++)
			begin
				if (subframeOrder[k] != parityPitch || pass == 0)
				begin
					expectTable[row] = '{subframeOrder[k], stepIndex_t'(frameSteps + k),
						6'(pass * subframeLength)};
					row++;
				end
			end
		end
		checkValue("tableRows", row, stepCount);
	endtask

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic watchIdle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clock);
			checkValue("unitStart", unitStart, '0);
			checkValue("encodeDone", encodeDone, 1'b0);
		end
	endtask

	task automatic pulseFrameDone();
		watchIdle(gatePause);
		frameDone <= 1'b1;
		@(posedge clock);
		frameDone <= 1'b0;
		checkValue("unitStart", unitStart, '0); // Go is one cycle behind
	endtask

	task automatic startAndGate();
		int pulse;
		@(posedge clock);
		start <= 1'b1;
		checkValue("unitStart", unitStart, '0);
		@(posedge clock);
		start <= 1'b0;
		checkValue("unitStart", unitStart, '0);
		for (pulse = 0; pulse < framesPerAnalysis; pulse++)
			pulseFrameDone();
	endtask

	task automatic waitForStart();
		do
		begin
			@(posedge clock);
			unitDone <= '0;
			checkValue("encodeDone", encodeDone, 1'b0);
		end
		while (unitStart === '0);
	endtask

	task automatic abortFrame(input unitFlags_t flags);
		divErr <= 1'b1;
		@(posedge clock);
		divErr <= 1'b0;
		unitDone <= flags; // Late done from the aborted unit
		checkValue("unitStart", unitStart, '0);
		@(posedge clock);
		unitDone <= '0;
		checkValue("unitStart", unitStart, '0);
		watchIdle(idleWatch);
	endtask

	task automatic finishFrame();
		@(posedge clock);
		unitDone <= '0;
		checkValue("encodeDone", encodeDone, 1'b0);
		@(posedge clock);
		checkValue("encodeDone", encodeDone, 1'b1);
		checkValue("unitStart", unitStart, '0);
		@(posedge clock);
		checkValue("encodeDone", encodeDone, 1'b0);
		watchIdle(idleWatch);
	endtask

	// Walks the table as the unit responder
	// A stopRow of -1 runs to the end
	task automatic runSequence(input int stopRow);
		int         row;
		int         delay;
		unitFlags_t flags;
		for (row = 0; row < stepCount; row++)
		begin
			flags = startFlag(expectTable[row].unit);
			waitForStart();
			checkValue("unitStart", unitStart, flags);
			checkValue("mathSel", mathSel, expectTable[row].step);
			checkValue("subframe", subframe, expectTable[row].offset);
			delay = ($urandom % 6) + 1;
			if (delay > 1)
				unitDone <= ~flags; // Dones from idle units
			repeat (delay - 1)
			begin
				@(posedge clock);
				unitDone <= '0;
				checkValue("unitStart", unitStart, '0); // Unit still busy
				checkValue("mathSel", mathSel, expectTable[row].step);
				checkValue("encodeDone", encodeDone, 1'b0);
			end
			if (row == stopRow)
			begin
				abortFrame(flags);
				return;
			end
			unitDone <= flags;
		end
		finishFrame();
	endtask

	initial
	begin
		start = 1'b0;
		frameDone = 1'b0;
		divErr = 1'b0;
		unitDone = '0;
		void'($urandom(32'ha00a9c54));
		buildTable();
		do
		begin
			@(posedge clock);
		end
		while (reset);
		checkValue("unitStart", unitStart, '0);
		checkValue("encodeDone", encodeDone, 1'b0);
		checkValue("mathSel", mathSel, '0);
		checkValue("subframe", subframe, '0);

		pulseFrameDone(); // Not counted before start
		startAndGate();
		runSequence(-1);
		startAndGate();
		runSequence(abortRow); // Division error in the first subframe
		startAndGate();
		runSequence(-1);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- list.f
rtl/g729Pkg.sv
rtl/frameGate.sv
rtl/encoderSchedule.sv
rtl/stepSequencer.sv
rtl/encoderControl.sv
bench/clockGen.sv
bench/encoderControlTb.sv

//--- rtl/encoderControl.sv
`timescale 1ns/1ps

module encoderControl
(
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  logic                frameDone,
	input  logic                divErr,
	input  g729Pkg::unitFlags_t unitDone,
	output g729Pkg::unitFlags_t unitStart,
	output g729Pkg::stepIndex_t mathSel,
	output logic [5:0]          subframe,
	output logic                encodeDone
);
	import g729Pkg::*;

	logic           analysisGo;
	scheduleEntry_t entry;

	frameGate gate
	(
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.frameDone  (frameDone),
		.analysisGo (analysisGo)
	);

	// The step index doubles as the math select
	encoderSchedule schedule
	(
		.stepIndex (mathSel),
		.entry     (entry)
	);

	stepSequencer sequencer
	(
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.divErr     (divErr),
		.analysisGo (analysisGo),
		.unitDone   (unitDone),
		.entry      (entry),
		.stepIndex  (mathSel),
		.unitStart  (unitStart),
		.subframe   (subframe),
		.encodeDone (encodeDone)
	);

endmodule

//--- rtl/encoderSchedule.sv
`timescale 1ns/1ps

module encoderSchedule
(
	input  g729Pkg::stepIndex_t     stepIndex,
	output g729Pkg::scheduleEntry_t entry
);
	import g729Pkg::*;

	function automatic scheduleEntry_t makeEntry
	(
		input unitId_t unit,
		input logic    gap,
		input logic    firstOnly,
		input logic    last
	);
		scheduleEntry_t e;
		e.unit = unit;
		e.gapBefore = gap;
		e.firstSubframeOnly = firstOnly;
		e.lastInPhase = last;
		return e;
	endfunction

	always_comb
	begin
		case (stepIndex)
			////////////////////////////////////////
			// Frame phase, LP analysis to open-loop pitch
			////////////////////////////////////////
			6'd0:  entry = makeEntry(autocorr,      1'b0, 1'b0, 1'b0);
			6'd1:  entry = makeEntry(lagWindow,     1'b0, 1'b0, 1'b0);
			6'd2:  entry = makeEntry(levinson,      1'b0, 1'b0, 1'b0);
			6'd3:  entry = makeEntry(azToLsp,       1'b0, 1'b0, 1'b0);
			6'd4:  entry = makeEntry(quaLsp,        1'b0, 1'b0, 1'b0);
			6'd5:  entry = makeEntry(intLpc,        1'b0, 1'b0, 1'b0);
			6'd6:  entry = makeEntry(intQlpc,       1'b0, 1'b0, 1'b0);
			6'd7:  entry = makeEntry(math1,         1'b0, 1'b0, 1'b0);
			6'd8:  entry = makeEntry(percVar,       1'b0, 1'b0, 1'b0);
			6'd9:  entry = makeEntry(weightAz,      1'b0, 1'b0, 1'b0); // Gamma1
			6'd10: entry = makeEntry(weightAz,      1'b1, 1'b0, 1'b0); // Gamma2
			6'd11: entry = makeEntry(residu,        1'b0, 1'b0, 1'b0);
			6'd12: entry = makeEntry(synFilt,       1'b0, 1'b0, 1'b0);
			6'd13: entry = makeEntry(weightAz,      1'b0, 1'b0, 1'b0); // Second half
			6'd14: entry = makeEntry(weightAz,      1'b1, 1'b0, 1'b0);
			6'd15: entry = makeEntry(residu,        1'b0, 1'b0, 1'b0);
			6'd16: entry = makeEntry(synFilt,       1'b0, 1'b0, 1'b0);
			6'd17: entry = makeEntry(pitchOl,       1'b0, 1'b0, 1'b0);
			6'd18: entry = makeEntry(math2,         1'b0, 1'b0, 1'b1); // Lag bounds
			////////////////////////////////////////
			// Subframe phase, run once per 40 samples
			////////////////////////////////////////
			6'd19: entry = makeEntry(weightAz,      1'b0, 1'b0, 1'b0);
			6'd20: entry = makeEntry(weightAz,      1'b1, 1'b0, 1'b0);
			6'd21: entry = makeEntry(math3,         1'b0, 1'b0, 1'b0);
			6'd22: entry = makeEntry(synFilt,       1'b0, 1'b0, 1'b0); // Impulse response
			6'd23: entry = makeEntry(synFilt,       1'b1, 1'b0, 1'b0);
			6'd24: entry = makeEntry(residu,        1'b0, 1'b0, 1'b0);
			6'd25: entry = makeEntry(synFilt,       1'b0, 1'b0, 1'b0);
			6'd26: entry = makeEntry(residu,        1'b0, 1'b0, 1'b0);
			6'd27: entry = makeEntry(synFilt,       1'b0, 1'b0, 1'b0); // Target signal
			6'd28: entry = makeEntry(pitchFr3,      1'b0, 1'b0, 1'b0);
			6'd29: entry = makeEntry(encLag3,       1'b0, 1'b0, 1'b0);
			6'd30: entry = makeEntry(parityPitch,   1'b0, 1'b1, 1'b0);
			6'd31: entry = makeEntry(predLt3,       1'b0, 1'b0, 1'b0);
			6'd32: entry = makeEntry(convolve,      1'b0, 1'b0, 1'b0);
			6'd33: entry = makeEntry(gPitch,        1'b0, 1'b0, 1'b0);
			6'd34: entry = makeEntry(testErr,       1'b0, 1'b0, 1'b0);
			6'd35: entry = makeEntry(math4,         1'b0, 1'b0, 1'b0);
			6'd36: entry = makeEntry(acelpCodebook, 1'b0, 1'b0, 1'b0);
			6'd37: entry = makeEntry(math5,         1'b0, 1'b0, 1'b0);
			6'd38: entry = makeEntry(corrXy2,       1'b0, 1'b0, 1'b0);
			6'd39: entry = makeEntry(quaGain,       1'b0, 1'b0, 1'b0);
			6'd40: entry = makeEntry(math6,         1'b0, 1'b0, 1'b0);
			6'd41: entry = makeEntry(updateExcErr,  1'b0, 1'b0, 1'b0);
			6'd42: entry = makeEntry(synFilt,       1'b0, 1'b0, 1'b0); // Filter memory update
			6'd43: entry = makeEntry(math7,         1'b0, 1'b0, 1'b1);
			default: entry = makeEntry(autocorr,    1'b0, 1'b0, 1'b1); // Out of table
		endcase
	end

endmodule

//--- rtl/frameGate.sv
`timescale 1ns/1ps

module frameGate
(
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic frameDone,
	output logic analysisGo
);
	import g729Pkg::*;

	logic       armed;      // Set once start has been seen
	logic [1:0] frameCount;
	logic       countHit;

	assign countHit = frameCount == 2'(framesPerAnalysis - 1);

	always_ff @(posedge clock)
	begin
		if (reset)
			armed <= 1'b0;
		else if (start)
			armed <= 1'b1;
	end

	// LP analysis runs on every second frame
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			frameCount <= '0;
			analysisGo <= 1'b0;
		end
		else
		begin
			analysisGo <= 1'b0;
			if (armed && frameDone)
			begin
				if (countHit)
				begin
					frameCount <= '0; // Restart count for later frames
					analysisGo <= 1'b1;
				end
				else
					frameCount <= frameCount + 1'b1;
			end
		end
	end

endmodule

//--- rtl/g729Pkg.sv
package g729Pkg;

	////////////////////////////////////////
	// Frame geometry
	////////////////////////////////////////

	localparam int frameLength       = 80; // Samples per frame
	localparam int subframeLength    = 40; // Samples per subframe
	localparam int framesPerAnalysis = 2;  // Frame-done pulses per LP analysis
	localparam int frameSteps        = 19; // Steps 0 to 18
	localparam int subframeSteps     = 25; // Steps 19 to 43

	// Step number, also drives the math select
	typedef logic [5:0] stepIndex_t;

	////////////////////////////////////////
	// Processing units
	////////////////////////////////////////

	// Enum value of a unit is its bit position in unitFlags_t
	typedef enum logic [4:0] {
		autocorr,
		lagWindow,
		levinson,
		azToLsp,
		quaLsp,
		intLpc,
		intQlpc,
		math1,
		percVar,
		weightAz,
		residu,
		synFilt,
		pitchOl,
		math2,
		math3,
		pitchFr3,
		encLag3,
		parityPitch,
		predLt3,
		convolve,
		gPitch,
		math4,
		testErr,
		acelpCodebook,
		math5,
		corrXy2,
		quaGain,
		math6,
		updateExcErr,
		math7
	} unitId_t;

	// Listed from MSB down, so autocorr sits at bit 0
	typedef struct packed {
		logic math7;
		logic updateExcErr;
		logic math6;
		logic quaGain;
		logic corrXy2;
		logic math5;
		logic acelpCodebook;
		logic testErr;
		logic math4;
		logic gPitch;
		logic convolve;
		logic predLt3;
		logic parityPitch;
		logic encLag3;
		logic pitchFr3;
		logic math3;
		logic math2;
		logic pitchOl;
		logic synFilt;
		logic residu;
		logic weightAz;
		logic percVar;
		logic math1;
		logic intQlpc;
		logic intLpc;
		logic quaLsp;
		logic azToLsp;
		logic levinson;
		logic lagWindow;
		logic autocorr;
	} unitFlags_t;

	typedef struct packed {
		unitId_t unit;
		logic    gapBefore;         // One idle cycle after the previous done
		logic    firstSubframeOnly; // Skipped when subframe is not 0
		logic    lastInPhase;       // End of frame phase or of a subframe pass
	} scheduleEntry_t;

endpackage

//--- rtl/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    start,
	input  logic                    divErr,
	input  logic                    analysisGo,
	input  g729Pkg::unitFlags_t     unitDone,
	input  g729Pkg::scheduleEntry_t entry,
	output g729Pkg::stepIndex_t     stepIndex,
	output g729Pkg::unitFlags_t     unitStart,
	output logic [5:0]              subframe,
	output logic                    encodeDone
);
	import g729Pkg::*;

	typedef enum logic [2:0] {
		idle,
		waitGo,
		gap,
		issue,
		waitDone,
		loopCheck,
		finish
	} state_t;

	state_t     state;
	state_t     nextState;
	stepIndex_t stepReg;
	stepIndex_t stepNext;
	logic [5:0] subframeNext;
	unitId_t    busyUnit;     // Unit started last
	unitId_t    busyUnitNext;
	logic       busyLast;     // Its step closes a phase
	logic       busyLastNext;
	logic       doneHit;
	logic       advance;
	logic       launch;
	logic       skipStep;
	logic [6:0] offsetSum;
	logic       finalStep;

	////////////////////////////////////////
	// Step lookup
	////////////////////////////////////////

	assign doneHit = unitDone[busyUnit]; // Done bits of idle units are ignored
	assign advance = (state == waitDone) && doneHit && !busyLast;

	// Look ahead on a done so the next start goes out in the same cycle
	assign stepIndex = advance ? stepReg + 1'b1 : stepReg;

	assign skipStep = entry.firstSubframeOnly && (subframe != '0);
	assign offsetSum = {1'b0, subframe} + 7'(subframeLength);
	assign finalStep = (stepReg == stepIndex_t'(frameSteps + subframeSteps - 1))
		&& (offsetSum >= 7'(frameLength));

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		stepNext = stepReg;
		subframeNext = subframe;
		busyUnitNext = busyUnit;
		busyLastNext = busyLast;
		launch = 1'b0;
		unitStart = '0;
		encodeDone = 1'b0;

		case (state)
			idle:
			begin
				if (start)
					nextState = waitGo;
			end
			waitGo:
			begin
				if (analysisGo)
				begin
					stepNext = '0;
					subframeNext = '0;
					nextState = issue;
				end
			end
			gap, issue:
				launch = 1'b1;
			waitDone:
			begin
				if (doneHit)
				begin
					if (busyLast)
						nextState = finalStep ? finish : loopCheck;
					else if (entry.gapBefore)
					begin
						stepNext = stepIndex; // Second issue of a pair
						nextState = gap;
					end
					else
						launch = 1'b1;
				end
			end
			loopCheck:
			begin
				// Frame phase ends at step 18, a pass adds one subframe
				if (stepReg != stepIndex_t'(frameSteps - 1))
					subframeNext = offsetSum[5:0];
				stepNext = stepIndex_t'(frameSteps);
				nextState = issue;
			end
			finish:
			begin
				encodeDone = 1'b1;
				stepNext = '0;
				subframeNext = '0;
				nextState = waitGo; // Ready for the next analysis go
			end
			default:
				nextState = idle;
		endcase

		if (launch)
		begin
			if (skipStep)
			begin
				stepNext = stepIndex + 1'b1; // Parity pitch in second subframe
				nextState = issue;
			end
			else
			begin
				unitStart[entry.unit] = 1'b1;
				busyUnitNext = entry.unit;
				busyLastNext = entry.lastInPhase;
				stepNext = stepIndex;
				nextState = waitDone;
			end
		end

		// Division error aborts the frame
		if (divErr)
		begin
			unitStart = '0;
			encodeDone = 1'b0;
			stepNext = '0;
			subframeNext = '0;
			nextState = idle;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
			stepReg <= '0;
			subframe <= '0;
		end
		else
		begin
			state <= nextState;
			stepReg <= stepNext;
			subframe <= subframeNext;
		end
	end

	always_ff @(posedge clock)
	begin
		busyUnit <= busyUnitNext;
		busyLast <= busyLastNext;
	end

endmodule
